// ==== snapshot.hex ====
// one byte per line, address = line order
// 00-1f register file, 20-3f data memory
01
04
07
0a
0d
10
13
16
19
1c
1f
22
25
28
2b
2e
31
34
37
3a
3d
40
43
46
49
4c
4f
52
55
58
5b
5e
61
64
67
6a
6d
70
73
76
79
7c
7f
82
85
88
8b
8e
91
94
97
9a
9d
a0
a3
a6
a9
ac
af
b2
b5
b8
bb
be

// ==== spart_debug.f ====
src/spart_debug_pkg.sv
src/snapshot_memory.sv
src/dump_pointers.sv
src/driver_fsm.sv
src/spart_debug_top.sv
verif/spart_debug_chk.sv
verif/spart_debug_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the debug console testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f spart_debug.f --top-module spart_debug_tb -o spart_debug_sim

./obj_dir/spart_debug_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "Testbench failed" sim.log; then
	echo "simulation FAILED, see sim.log"
	exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
	echo "simulation ended without a result, see sim.log"
	exit 1
fi
echo "simulation OK"

// ==== verif/spart_debug_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module spart_debug_tb;
	import spart_debug_pkg::*;

	// one table row, either a reset with a switch setting or a key press
	typedef struct packed {
		logic       do_reset;
		logic [1:0] cfg;
		byte_t      cmd;
	} step_t;

	localparam int num_steps       = 15;
	localparam int step_budget     = 4000;
	localparam int watchdog_cycles = 2 * num_steps * step_budget + 4 * 40;
	localparam byte_t digit_base   = 8'h30;
	localparam byte_t space_byte   = 8'h20;

	// DUT inputs
	logic       clk;
	logic       rst;
	logic [1:0] br_cfg;
	logic       rda;
	logic       tbr = 1'b1;
	byte_t      databus_in;

	// DUT outputs
	logic       iocs;
	logic       iorw;
	logic [1:0] ioaddr;
	byte_t      databus_out;
	logic       databus_oe;

	// stall source
	int          seed = 65;
	logic [31:0] rand_word;
	logic        random_tbr = 1'b0;

	// bytes seen on the bus
	byte_t      tx_q [$];
	logic [1:0] wr_addr_q [$];
	byte_t      wr_data_q [$];

	// reference model state
	byte_t snap_image [64];
	byte_t exp_q [$];
	byte_t model_index;
	int    model_mem_ptr;

	int check_errors   = 0;
	int monitor_errors = 0;

	// divisors per br_cfg, low byte goes out first
	logic [15:0] expected_divisor [4] = '{16'h12c0, 16'h2580, 16'h4b00, 16'h9600};

	// 'a' and 'z' must be ignored
	step_t steps [num_steps] = '{
		'{1'b1, 2'd0, 8'h00},
		'{1'b0, 2'd0, 8'h32},
		'{1'b0, 2'd0, 8'h32},
		'{1'b0, 2'd0, 8'h32},
		'{1'b0, 2'd0, 8'h31},
		'{1'b0, 2'd0, 8'h61},
		'{1'b0, 2'd0, 8'h0d},
		'{1'b0, 2'd0, 8'h0d},
		'{1'b1, 2'd1, 8'h00},
		'{1'b0, 2'd1, 8'h31},
		'{1'b0, 2'd1, 8'h0d},
		'{1'b0, 2'd1, 8'h32},
		'{1'b1, 2'd3, 8'h00},
		'{1'b0, 2'd3, 8'h0d},
		'{1'b0, 2'd3, 8'h7a}
	};

	spart_debug_top u_spart_debug_top (
		.clk         (clk),
		.rst         (rst),
		.br_cfg      (br_cfg),
		.rda         (rda),
		.tbr         (tbr),
		.databus_in  (databus_in),
		.iocs        (iocs),
		.iorw        (iorw),
		.ioaddr      (ioaddr),
		.databus_out (databus_out),
		.databus_oe  (databus_oe)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// transmitter ready, about two cycles in three when stalling
	always @(posedge clk) begin
		if (random_tbr) begin
			rand_word = $random(seed);
			tbr <= (rand_word % 32'd3) != 32'd0;
		end else begin
			tbr <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// SPART side of the bus
	////////////////////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		if (rst) begin
			// bus released, read direction
			if (databus_oe || !iorw) begin
				monitor_errors = monitor_errors + 1;
				$display("Error at %0t: bus driven or iorw low during reset", $time);
			end
		end else if (databus_oe) begin
			if (!iorw) begin
				if (!tbr) begin
					monitor_errors = monitor_errors + 1;
					$display("Error at %0t: byte %h sent while tbr low", $time, databus_out);
				end
				if (ioaddr != 2'd0) begin
					monitor_errors = monitor_errors + 1;
					$display("Error at %0t: transmit write to address %0d", $time, ioaddr);
				end
				tx_q.push_back(databus_out);
			end else begin
				// divisor writes
				wr_addr_q.push_back(ioaddr);
				wr_data_q.push_back(databus_out);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////
	function automatic void build_expected(input byte_t cmd);
		int idx;
		int i;
		exp_q.delete();
		if (cmd == 8'h31) begin
			model_index = model_index - 8'd1;
			exp_q.push_back(space_byte);
		end else if (cmd == 8'h32) begin
			model_index = model_index + 8'd1;
			exp_q.push_back(space_byte);
		end else if (cmd == 8'h0d) begin
			// register section, index digit then value digit
			while (model_index < 8'd10) begin
				idx = int'(model_index[4:0]);
				exp_q.push_back(model_index + digit_base);
				exp_q.push_back(snap_image[idx] + digit_base);
				exp_q.push_back(space_byte);
				model_index = model_index + 8'd1;
			end
			// memory section only while the pointer never moved
			if (model_mem_ptr == 0) begin
				for (i = 0; i < 10; i++) begin
					exp_q.push_back(snap_image[32 + i] + digit_base);
					exp_q.push_back(space_byte);
				end
				model_mem_ptr = 10;
			end
		end
	endfunction

	// reset, then expect both divisor bytes
	task automatic reset_dut(input logic [1:0] cfg);
		int          base;
		logic [15:0] div;
		div = expected_divisor[cfg];
		@(posedge clk);
		rst        <= 1'b1;
		br_cfg     <= cfg;
		rda        <= 1'b0;
		databus_in <= 8'h00;
		repeat (4) @(posedge clk);
		base = wr_addr_q.size();
		rst <= 1'b0;
		model_index   = 8'h00;
		model_mem_ptr = 0;
		while (wr_addr_q.size() - base < 2) @(posedge clk);
		if (wr_addr_q[base] != 2'd2 || wr_data_q[base] != div[7:0]) begin
			check_errors = check_errors + 1;
			$display("Error at %0t: br_cfg %0d first write %0d %h, expected 2 %h",
				$time, cfg, wr_addr_q[base], wr_data_q[base], div[7:0]);
		end
		if (wr_addr_q[base + 1] != 2'd3 || wr_data_q[base + 1] != div[15:8]) begin
			check_errors = check_errors + 1;
			$display("Error at %0t: br_cfg %0d second write %0d %h, expected 3 %h",
				$time, cfg, wr_addr_q[base + 1], wr_data_q[base + 1], div[15:8]);
		end
		repeat (4) @(posedge clk);
	endtask

	// one key press, wait for the full answer, then look for extras
	task automatic apply_command(input byte_t cmd);
		int base;
		int got;
		int i;
		base = tx_q.size();
		build_expected(cmd);
		@(posedge clk);
		// idle FSM polls the SPART with iocs low
		if (iocs !== 1'b0) begin
			check_errors = check_errors + 1;
			$display("Error at %0t: iocs %b while idle, expected 0", $time, iocs);
		end
		rda        <= 1'b1;
		databus_in <= cmd;
		@(posedge clk);
		rda        <= 1'b0;
		databus_in <= 8'h00;
		while (tx_q.size() - base < exp_q.size()) @(posedge clk);
		repeat (20) @(posedge clk);
		got = tx_q.size() - base;
		if (got != exp_q.size()) begin
			check_errors = check_errors + 1;
			$display("Error at %0t: cmd %h gave %0d bytes, expected %0d",
				$time, cmd, got, exp_q.size());
		end
		for (i = 0; i < got && i < exp_q.size(); i++) begin
			if (tx_q[base + i] != exp_q[i]) begin
				check_errors = check_errors + 1;
				$display("Error at %0t: cmd %h byte %0d got %h expected %h",
					$time, cmd, i, tx_q[base + i], exp_q[i]);
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		int cfg;
		int pass_no;
		int s;
		int assert_fails;
		rst        <= 1'b1;
		br_cfg     <= 2'd0;
		rda        <= 1'b0;
		databus_in <= 8'h00;
		$readmemh(snapshot_file, snap_image);
		// divisor bytes for every switch setting
		for (cfg = 0; cfg < 4; cfg++) begin
			reset_dut(2'(cfg));
		end
		// first pass tbr always high, second pass with stalls
		for (pass_no = 0; pass_no < 2; pass_no++) begin
			random_tbr <= (pass_no == 1);
			for (s = 0; s < num_steps; s++) begin
				if (steps[s].do_reset) begin
					reset_dut(steps[s].cfg);
				end else begin
					apply_command(steps[s].cmd);
				end
			end
		end
		assert_fails = u_spart_debug_top.u_driver_fsm.u_spart_debug_chk.fail_count;
		$display("Check errors: %0d, bus monitor errors: %0d, assertion failures: %0d",
			check_errors, monitor_errors, assert_fails);
		if (check_errors == 0 && monitor_errors == 0 && assert_fails == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// a missing byte leaves the main sequence waiting
	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Timeout after %0d cycles, the DUT stopped responding", watchdog_cycles);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/spart_debug_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module spart_debug_chk (
	input logic       clk,
	input logic       rst,
	input logic       rda,
	input logic       tbr,
	input logic       iocs,
	input logic       iorw,
	input logic [1:0] ioaddr,
	input logic       databus_oe
);
	import spart_debug_pkg::*;

	// per rule failure counts
	int fail_oe   = 0;
	int fail_tx   = 0;
	int fail_cs   = 0;
	int fail_low  = 0;
	int fail_high = 0;
	int fail_count;

	assign fail_count = fail_oe + fail_tx + fail_cs + fail_low + fail_high;

	////////////////////////////////////////////////////////////////////////////
	// bus rules
	////////////////////////////////////////////////////////////////////////////
	oe_on_write: assert property (@(posedge clk) disable iff (rst) !iorw |-> databus_oe)
		else begin
			$error("iorw low without databus_oe");
			fail_oe = fail_oe + 1;
		end

	// transmit only to the tx register with the transmitter ready
	tx_when_ready: assert property (@(posedge clk) disable iff (rst)
		!iorw |-> (tbr && ioaddr == ioaddr_tx_data))
		else begin
			$error("transmit write without tbr or at wrong address");
			fail_tx = fail_tx + 1;
		end

	cs_while_idle: assert property (@(posedge clk) disable iff (rst) !iocs |-> !rda)
		else begin
			$error("iocs low while rda high");
			fail_cs = fail_cs + 1;
		end

	// divisor low byte right after reset release
	baud_low_first: assert property (@(posedge clk) disable iff (rst)
		$fell(rst) |-> (databus_oe && iorw && ioaddr == ioaddr_div_low))
		else begin
			$error("first cycle after reset is not the divisor low write");
			fail_low = fail_low + 1;
		end

	// then the high byte
	baud_high_next: assert property (@(posedge clk) disable iff (rst)
		($past(rst, 2) && !$past(rst)) |-> (databus_oe && iorw && ioaddr == ioaddr_div_high))
		else begin
			$error("second cycle after reset is not the divisor high write");
			fail_high = fail_high + 1;
		end

endmodule

bind driver_fsm spart_debug_chk u_spart_debug_chk (
	.clk        (clk),
	.rst        (rst),
	.rda        (rda),
	.tbr        (tbr),
	.iocs       (iocs),
	.iorw       (iorw),
	.ioaddr     (ioaddr),
	.databus_oe (databus_oe)
);

`default_nettype wire

// ==== src/spart_debug_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module spart_debug_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [1:0]             br_cfg,
	input  logic                   rda,
	input  logic                   tbr,
	input  spart_debug_pkg::byte_t databus_in,
	output logic                   iocs,
	output logic                   iorw,
	output logic [1:0]             ioaddr,
	output spart_debug_pkg::byte_t databus_out,
	output logic                   databus_oe
);
	import spart_debug_pkg::*;

	// strobes from the FSM to the counters
	logic index_inc;
	logic index_dec;
	logic mem_inc;

	// counter state and limit flags
	byte_t      dump_index;
	logic [4:0] mem_ptr;
	logic       index_done;
	logic       mem_done;
	logic       mem_at_start;

	// snapshot read data
	byte_t reg_value;
	byte_t mem_value;

	////////////////////////////////////////////////////////////////////////////
	// bus FSM
	////////////////////////////////////////////////////////////////////////////
	driver_fsm u_driver_fsm (
		.clk          (clk),
		.rst          (rst),
		.br_cfg       (br_cfg),
		.rda          (rda),
		.tbr          (tbr),
		.databus_in   (databus_in),
		.reg_value    (reg_value),
		.mem_value    (mem_value),
		.index_done   (index_done),
		.mem_done     (mem_done),
		.mem_at_start (mem_at_start),
		.dump_index   (dump_index),
		.iocs         (iocs),
		.iorw         (iorw),
		.ioaddr       (ioaddr),
		.databus_out  (databus_out),
		.databus_oe   (databus_oe),
		.index_inc    (index_inc),
		.index_dec    (index_dec),
		.mem_inc      (mem_inc)
	);

	////////////////////////////////////////////////////////////////////////////
	// dump counters and snapshot
	////////////////////////////////////////////////////////////////////////////
	dump_pointers u_dump_pointers (
		.clk          (clk),
		.rst          (rst),
		.index_inc    (index_inc),
		.index_dec    (index_dec),
		.mem_inc      (mem_inc),
		.dump_index   (dump_index),
		.mem_ptr      (mem_ptr),
		.index_done   (index_done),
		.mem_done     (mem_done),
		.mem_at_start (mem_at_start)
	);

	snapshot_memory u_snapshot_memory (
		.dump_index (dump_index),
		.mem_ptr    (mem_ptr),
		.reg_value  (reg_value),
		.mem_value  (mem_value)
	);

endmodule

`default_nettype wire

// ==== src/driver_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module driver_fsm (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [1:0]             br_cfg,
	input  logic                   rda,
	input  logic                   tbr,
	input  spart_debug_pkg::byte_t databus_in,
	input  spart_debug_pkg::byte_t reg_value,
	input  spart_debug_pkg::byte_t mem_value,
	input  logic                   index_done,
	input  logic                   mem_done,
	input  logic                   mem_at_start,
	input  spart_debug_pkg::byte_t dump_index,
	output logic                   iocs,
	output logic                   iorw,
	output logic [1:0]             ioaddr,
	output spart_debug_pkg::byte_t databus_out,
	output logic                   databus_oe,
	output logic                   index_inc,
	output logic                   index_dec,
	output logic                   mem_inc
);
	import spart_debug_pkg::*;

	driver_state_t state;
	driver_state_t next_state;

	// divisor picked by the board switches
	logic [15:0] divisor;

	// ascii digits, plain add, wraps past 8 bits
	byte_t index_digit;
	byte_t reg_digit;
	byte_t mem_digit;

	// one byte to the transmitter this cycle
	logic  tx_load;
	byte_t tx_byte;

	assign divisor     = baud_divisor[br_cfg];
	assign index_digit = dump_index + ascii_zero;
	assign reg_digit   = reg_value + ascii_zero;
	assign mem_digit   = mem_value + ascii_zero;

	////////////////////////////////////////////////////////////////////////////
	// state register
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= init_low_db;
		end else begin
			state <= next_state;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// next state and bus outputs
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		// idle bus, read direction, tx address
		next_state  = state;
		iocs        = 1'b1;
		iorw        = 1'b1;
		ioaddr      = ioaddr_tx_data;
		databus_out = '0;
		databus_oe  = 1'b0;
		index_inc   = 1'b0;
		index_dec   = 1'b0;
		mem_inc     = 1'b0;
		tx_load     = 1'b0;
		tx_byte     = ascii_space;

		case (state)
			// divisor low byte, iorw stays high
			init_low_db: begin
				ioaddr      = ioaddr_div_low;
				databus_out = divisor[7:0];
				// bus stays released while reset is held
				databus_oe  = ~rst;
				next_state  = init_high_db;
			end
			// divisor high byte
			init_high_db: begin
				ioaddr      = ioaddr_div_high;
				databus_out = divisor[15:8];
				databus_oe  = 1'b1;
				next_state  = receive_wait;
			end
			// poll rda, decode the byte in the cycle it shows up
			receive_wait: begin
				if (!rda) begin
					iocs = 1'b0;
				end else begin
					case (databus_in)
						cmd_enter: begin
							next_state = send_index;
						end
						cmd_dec: begin
							index_dec  = 1'b1;
							next_state = print_pc;
						end
						cmd_inc: begin
							index_inc  = 1'b1;
							next_state = print_pc;
						end
						// anything else is dropped
						default: begin
							next_state = receive_wait;
						end
					endcase
				end
			end
			// index digit, or skip to memory once past the last entry
			send_index: begin
				if (index_done) begin
					next_state = print_memory;
				end else if (tbr) begin
					tx_load    = 1'b1;
					tx_byte    = index_digit;
					next_state = send_reg;
				end
			end
			// register digit, then step the index
			send_reg: begin
				if (tbr) begin
					tx_load    = 1'b1;
					tx_byte    = reg_digit;
					index_inc  = 1'b1;
					next_state = next_line;
				end
			end
			// memory digit, pointer never rewinds
			print_memory: begin
				if (mem_done) begin
					next_state = receive_wait;
				end else if (tbr) begin
					tx_load    = 1'b1;
					tx_byte    = mem_digit;
					mem_inc    = 1'b1;
					next_state = next_line;
				end
			end
			// separator space
			next_line: begin
				if (tbr) begin
					tx_load = 1'b1;
					// pointer still at 0 means register section is running
					if (mem_at_start) begin
						next_state = send_index;
					end else begin
						next_state = print_memory;
					end
				end
			end
			// single space answers a '1' or '2'
			print_pc: begin
				if (tbr) begin
					tx_load    = 1'b1;
					next_state = receive_wait;
				end
			end
			default: begin
				next_state = init_low_db;
			end
		endcase

		// transmit write, tbr already checked by the state
		if (tx_load) begin
			iorw        = 1'b0;
			ioaddr      = ioaddr_tx_data;
			databus_out = tx_byte;
			databus_oe  = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/dump_pointers.sv ====
`timescale 1ns/1ps
`default_nettype none

module dump_pointers (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   index_inc,
	input  logic                   index_dec,
	input  logic                   mem_inc,
	output spart_debug_pkg::byte_t dump_index,
	output logic [4:0]             mem_ptr,
	output logic                   index_done,
	output logic                   mem_done,
	output logic                   mem_at_start
);
	import spart_debug_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// counters
	////////////////////////////////////////////////////////////////////////////

	// dump index, wraps both ways, inc wins over dec
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			dump_index <= '0;
		end else if (index_inc) begin
			dump_index <= dump_index + 8'd1;
		end else if (index_dec) begin
			dump_index <= dump_index - 8'd1;
		end
	end

	// memory pointer, only counts up
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mem_ptr <= '0;
		end else if (mem_inc) begin
			mem_ptr <= mem_ptr + 5'd1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// limit flags
	////////////////////////////////////////////////////////////////////////////

	// 255 after a wrap also counts as done
	assign index_done   = (dump_index >= byte_t'(dump_length));
	assign mem_done     = (mem_ptr >= 5'(dump_length));
	assign mem_at_start = (mem_ptr == '0);

endmodule

`default_nettype wire

// ==== src/snapshot_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module snapshot_memory (
	input  spart_debug_pkg::byte_t dump_index,
	input  logic [4:0]             mem_ptr,
	output spart_debug_pkg::byte_t reg_value,
	output spart_debug_pkg::byte_t mem_value
);
	import spart_debug_pkg::*;

	// register file image then data memory image
	byte_t snap_mem [2**snap_addr_width];

	logic [snap_addr_width-1:0] reg_addr;
	logic [snap_addr_width-1:0] mem_addr;

	initial begin
		$readmemh(snapshot_file, snap_mem);
	end

	// 32 registers, low five index bits select one
	assign reg_addr = snap_addr_width'(dump_index[4:0]);
	// data memory sits above the registers
	assign mem_addr = snap_addr_width'(mem_region_base) + snap_addr_width'(mem_ptr);

	// async reads, same cycle as the address
	assign reg_value = snap_mem[reg_addr];
	assign mem_value = snap_mem[mem_addr];

endmodule

`default_nettype wire

// ==== src/spart_debug_pkg.sv ====
`default_nettype none

package spart_debug_pkg;

	// one byte on the spart data bus
	typedef logic [7:0] byte_t;

	// driver states, encoded as in the console FSM
	typedef enum logic [3:0] {
		init_low_db,
		init_high_db,
		receive_wait,
		send_index,
		send_reg,
		print_memory,
		next_line,
		print_pc
	} driver_state_t;

	// spart register addresses
	localparam logic [1:0] ioaddr_tx_data  = 2'd0;
	localparam logic [1:0] ioaddr_div_low  = 2'd2;
	localparam logic [1:0] ioaddr_div_high = 2'd3;

	// console keys the driver reacts to
	typedef enum logic [7:0] {
		cmd_enter = 8'h0d,
		cmd_dec   = 8'h31,
		cmd_inc   = 8'h32
	} cmd_t;

	localparam byte_t ascii_zero  = 8'h30;
	localparam byte_t ascii_space = 8'h20;

	// baud divisors, entry n selected by br_cfg == n
	localparam logic [3:0][15:0] baud_divisor = {16'h9600, 16'h4b00, 16'h2580, 16'h12c0};

	// entries per dump section
	localparam int unsigned dump_length = 10;

	// snapshot layout, registers low half, data memory high half
	localparam int unsigned snap_addr_width = 6;
	localparam int unsigned mem_region_base = 32;
	localparam string snapshot_file = "snapshot.hex";

endpackage

`default_nettype wire
